// ==== hw/dmem_pkg.sv ====
`default_nettype none

// shared constants for the data-memory stage
package dmem_pkg;

    // core data and address width, fixed for rv32
    localparam int unsigned xlen = 32;

    // lane geometry of one word
    localparam int unsigned byte_lanes = 4;  // bytes per word
    localparam int unsigned lane_idx_w = 2;  // byte index inside a word
    localparam int unsigned byte_w     = 8;  // bits per byte lane
    localparam int unsigned half_w     = 16; // bits per halfword

    // load funct3 codes
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // store funct3 codes, same values as the signed loads
    // the write bit tells them apart
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

endpackage

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte-addressed data memory shared by both pipelines
// two combinational read ports, two byte-strobed write ports
// the port address is the word address and serves both read and write
module data_mem #(
    parameter int ADDRESS_WIDTH = 10
) (
    input  logic                            clk,
    input  logic [ADDRESS_WIDTH-1:0]        rd_addr1, // pipe 1 word address
    input  logic [ADDRESS_WIDTH-1:0]        rd_addr2, // pipe 2 word address
    input  logic [dmem_pkg::byte_lanes-1:0] byte_en1, // pipe 1 lane strobes
    input  logic [dmem_pkg::byte_lanes-1:0] byte_en2, // pipe 2 lane strobes
    input  logic [dmem_pkg::xlen-1:0]       wdata1,   // already lane-placed
    input  logic [dmem_pkg::xlen-1:0]       wdata2,
    output logic [dmem_pkg::xlen-1:0]       rdata1,   // whole word, little-endian
    output logic [dmem_pkg::xlen-1:0]       rdata2
);

    localparam int nl    = dmem_pkg::byte_lanes;
    localparam int lw    = dmem_pkg::lane_idx_w;
    localparam int bw    = dmem_pkg::byte_w;
    localparam int row_w = ADDRESS_WIDTH - lw;  // word index width
    localparam int depth = 2 ** ADDRESS_WIDTH;  // bytes

    logic [bw-1:0] ram [depth];

    logic [row_w-1:0] row1;
    logic [row_w-1:0] row2;

    // drop the lane bits, the units clear them anyway
    assign row1 = rd_addr1[ADDRESS_WIDTH-1:lw];
    assign row2 = rd_addr2[ADDRESS_WIDTH-1:lw];

    // byte address of one lane of a word
    function automatic logic [ADDRESS_WIDTH-1:0] lane_addr(
        input logic [row_w-1:0] row,
        input int               lane
    );
        lane_addr = {row, lw'(lane)};
    endfunction

    initial begin
        $readmemh("data.hex", ram); // only the low bytes are given
    end

    // read side, sees memory as it was before the edge
    always_comb begin
        for (int i = 0; i < nl; i++) begin
            rdata1[i*bw +: bw] = ram[lane_addr(row1, i)];
            rdata2[i*bw +: bw] = ram[lane_addr(row2, i)];
        end
    end

    // write side
    // port 1 lanes first, then port 2 lanes
    // last nonblocking write to a byte wins, so pipe 2 (the younger
    // instruction) owns overlapping bytes, all other strobed bytes land
    always_ff @(posedge clk) begin
        for (int i = 0; i < nl; i++) begin
            if (byte_en1[i]) begin
                ram[lane_addr(row1, i)] <= wdata1[i*bw +: bw];
            end
        end
        for (int i = 0; i < nl; i++) begin
            if (byte_en2[i]) begin
                ram[lane_addr(row2, i)] <= wdata2[i*bw +: bw]; // overrides port 1
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_access_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-pipeline memory access unit
// store: lane placement and byte strobes
// load: lane select, sign/zero extension, one-cycle registered result
// misaligned half/word accesses are flagged and dropped
module mem_access_unit #(
    parameter int ADDRESS_WIDTH = 10
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req,         // one access this cycle
    input  logic                            wr,          // store when high
    input  logic [2:0]                      funct3,
    input  logic [dmem_pkg::xlen-1:0]       addr,        // byte address
    input  logic [dmem_pkg::xlen-1:0]       wdata,       // raw store data
    input  logic [dmem_pkg::xlen-1:0]       rdata_word,  // from data_mem, same cycle
    output logic [ADDRESS_WIDTH-1:0]        word_addr,
    output logic [dmem_pkg::byte_lanes-1:0] byte_en,
    output logic [dmem_pkg::xlen-1:0]       wdata_lanes,
    output logic                            load_valid,
    output logic [dmem_pkg::xlen-1:0]       load_data,
    output logic                            misalign
);

    localparam int xw = dmem_pkg::xlen;
    localparam int nl = dmem_pkg::byte_lanes;
    localparam int lw = dmem_pkg::lane_idx_w;
    localparam int bw = dmem_pkg::byte_w;
    localparam int hw = dmem_pkg::half_w;

    logic [lw-1:0] lane;        // byte offset in word
    logic          is_half;
    logic          is_word;
    logic          bad_align;
    logic [nl-1:0] st_mask;     // strobes before gating
    logic [bw-1:0] ld_byte;
    logic [hw-1:0] ld_half;
    logic [xw-1:0] ld_ext;
    logic          ld_take;     // load accepted this cycle

    assign lane = addr[lw-1:0];

    // word-aligned address into memory
    assign word_addr = {addr[ADDRESS_WIDTH-1:lw], {lw{1'b0}}};

    // size from the low funct3 bits, same for loads and stores
    assign is_half = (funct3[1:0] == dmem_pkg::f3_lh[1:0]);
    assign is_word = (funct3[1:0] == dmem_pkg::f3_lw[1:0]);

    // bytes never misalign
    assign bad_align = (is_half & lane[0]) | (is_word & (lane != '0));

    assign ld_take = req & ~wr & ~bad_align;

    // store lane placement
    always_comb begin
        case (funct3)
            dmem_pkg::f3_sb: begin
                wdata_lanes = {nl{wdata[bw-1:0]}};   // byte in every lane
                st_mask     = nl'(1) << lane;
            end
            dmem_pkg::f3_sh: begin
                wdata_lanes = {(xw/hw){wdata[hw-1:0]}}; // half in both halves
                st_mask     = nl'(3) << lane;          // lane is 0 or 2 here
            end
            dmem_pkg::f3_sw: begin
                wdata_lanes = wdata;
                st_mask     = '1;
            end
            default: begin
                wdata_lanes = wdata;
                st_mask     = '0;                     // not a store size
            end
        endcase
    end

    // strobes are the only write qualifier
    assign byte_en = (req & wr & ~bad_align) ? st_mask : '0;

    // load lane select
    assign ld_byte = rdata_word[lane*bw +: bw];
    assign ld_half = rdata_word[lane[lw-1]*hw +: hw]; // upper or lower half

    always_comb begin
        case (funct3)
            dmem_pkg::f3_lb:  ld_ext = {{(xw-bw){ld_byte[bw-1]}}, ld_byte};
            dmem_pkg::f3_lh:  ld_ext = {{(xw-hw){ld_half[hw-1]}}, ld_half};
            dmem_pkg::f3_lw:  ld_ext = rdata_word;
            dmem_pkg::f3_lbu: ld_ext = {{(xw-bw){1'b0}}, ld_byte};
            dmem_pkg::f3_lhu: ld_ext = {{(xw-hw){1'b0}}, ld_half};
            default:          ld_ext = '0;            // undefined load size
        endcase
    end

    // result stage, valid the cycle after the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_valid <= 1'b0;
            load_data  <= '0;
            misalign   <= 1'b0;
        end else begin
            load_valid <= ld_take;
            misalign   <= req & bad_align;    // one-cycle pulse
            if (ld_take) begin
                load_data <= ld_ext;          // hold last result otherwise
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dual_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// memory stage of the two-pipeline core
// one access unit per pipeline, both sharing one data memory
module dual_mem_stage #(
    parameter int ADDRESS_WIDTH = 10
) (
    input  logic                      clk,
    input  logic                      arst_n,
    // pipeline 1, older instruction
    input  logic                      req_1,
    input  logic                      wr_1,
    input  logic [2:0]                funct3_1,
    input  logic [dmem_pkg::xlen-1:0] addr_1,
    input  logic [dmem_pkg::xlen-1:0] wdata_1,
    output logic                      load_valid_1,
    output logic [dmem_pkg::xlen-1:0] load_data_1,
    output logic                      misalign_1,
    // pipeline 2, younger instruction
    input  logic                      req_2,
    input  logic                      wr_2,
    input  logic [2:0]                funct3_2,
    input  logic [dmem_pkg::xlen-1:0] addr_2,
    input  logic [dmem_pkg::xlen-1:0] wdata_2,
    output logic                      load_valid_2,
    output logic [dmem_pkg::xlen-1:0] load_data_2,
    output logic                      misalign_2
);

    logic [ADDRESS_WIDTH-1:0]        word_addr_1;
    logic [ADDRESS_WIDTH-1:0]        word_addr_2;
    logic [dmem_pkg::byte_lanes-1:0] byte_en_1;
    logic [dmem_pkg::byte_lanes-1:0] byte_en_2;
    logic [dmem_pkg::xlen-1:0]       wdata_lanes_1;
    logic [dmem_pkg::xlen-1:0]       wdata_lanes_2;
    logic [dmem_pkg::xlen-1:0]       rdata_word_1;
    logic [dmem_pkg::xlen-1:0]       rdata_word_2;

    mem_access_unit #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) pipe1_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req_1),
        .wr         (wr_1),
        .funct3     (funct3_1),
        .addr       (addr_1),
        .wdata      (wdata_1),
        .rdata_word (rdata_word_1),
        .word_addr  (word_addr_1),
        .byte_en    (byte_en_1),
        .wdata_lanes(wdata_lanes_1),
        .load_valid (load_valid_1),
        .load_data  (load_data_1),
        .misalign   (misalign_1)
    );

    mem_access_unit #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) pipe2_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req_2),
        .wr         (wr_2),
        .funct3     (funct3_2),
        .addr       (addr_2),
        .wdata      (wdata_2),
        .rdata_word (rdata_word_2),
        .word_addr  (word_addr_2),
        .byte_en    (byte_en_2),
        .wdata_lanes(wdata_lanes_2),
        .load_valid (load_valid_2),
        .load_data  (load_data_2),
        .misalign   (misalign_2)
    );

    // port 2 wins on overlapping bytes
    data_mem #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) dmem_i (
        .clk     (clk),
        .rd_addr1(word_addr_1),
        .rd_addr2(word_addr_2),
        .byte_en1(byte_en_1),
        .byte_en2(byte_en_2),
        .wdata1  (wdata_lanes_1),
        .wdata2  (wdata_lanes_2),
        .rdata1  (rdata_word_1),
        .rdata2  (rdata_word_2)
    );

endmodule

`default_nettype wire

// ==== verif/dual_mem_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// strobe, load timing and misalignment properties of the memory stage
module dual_mem_stage_checker (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            req_1,
    input logic                            wr_1,
    input logic [dmem_pkg::byte_lanes-1:0] byte_en_1,
    input logic                            load_valid_1,
    input logic                            misalign_1,
    input logic                            req_2,
    input logic                            wr_2,
    input logic [dmem_pkg::byte_lanes-1:0] byte_en_2,
    input logic                            load_valid_2,
    input logic                            misalign_2
);

    // strobes only for a store that turns out aligned
    strobe_1: assert property (@(posedge clk) disable iff (!arst_n)
        $past(byte_en_1 != '0) |-> ($past(req_1 && wr_1) && !misalign_1))
        else $error("pipe 1 byte strobes without an aligned store");
    strobe_2: assert property (@(posedge clk) disable iff (!arst_n)
        $past(byte_en_2 != '0) |-> ($past(req_2 && wr_2) && !misalign_2))
        else $error("pipe 2 byte strobes without an aligned store");

    // exactly one cycle after each aligned load
    load_lat_1: assert property (@(posedge clk) disable iff (!arst_n)
        load_valid_1 == ($past(req_1 && !wr_1) && !misalign_1))
        else $error("pipe 1 load_valid out of step with its request");
    load_lat_2: assert property (@(posedge clk) disable iff (!arst_n)
        load_valid_2 == ($past(req_2 && !wr_2) && !misalign_2))
        else $error("pipe 2 load_valid out of step with its request");

    excl_1: assert property (@(posedge clk) disable iff (!arst_n)
        !(load_valid_1 && misalign_1))
        else $error("pipe 1 load_valid and misalign together");
    excl_2: assert property (@(posedge clk) disable iff (!arst_n)
        !(load_valid_2 && misalign_2))
        else $error("pipe 2 load_valid and misalign together");

endmodule

// byte_en nets are internal to the top
bind dual_mem_stage dual_mem_stage_checker checker_i (
    .clk(clk), .arst_n(arst_n),
    .req_1(req_1), .wr_1(wr_1), .byte_en_1(byte_en_1),
    .load_valid_1(load_valid_1), .misalign_1(misalign_1),
    .req_2(req_2), .wr_2(wr_2), .byte_en_2(byte_en_2),
    .load_valid_2(load_valid_2), .misalign_2(misalign_2)
);

`default_nettype wire

// ==== verif/dual_mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the dual-pipeline memory stage
// a byte-array model of the memory predicts every result
module dual_mem_stage_tb;

    localparam int addr_w     = 10;
    localparam int hex_bytes  = 64;   // region covered by data.hex
    localparam int max_cycles = 2000; // tests need about 500 cycles

    logic                      clk;
    logic                      arst_n;
    logic                      req_1;
    logic                      wr_1;
    logic [2:0]                funct3_1;
    logic [dmem_pkg::xlen-1:0] addr_1;
    logic [dmem_pkg::xlen-1:0] wdata_1;
    logic                      load_valid_1;
    logic [dmem_pkg::xlen-1:0] load_data_1;
    logic                      misalign_1;
    logic                      req_2;
    logic                      wr_2;
    logic [2:0]                funct3_2;
    logic [dmem_pkg::xlen-1:0] addr_2;
    logic [dmem_pkg::xlen-1:0] wdata_2;
    logic                      load_valid_2;
    logic [dmem_pkg::xlen-1:0] load_data_2;
    logic                      misalign_2;

    logic [7:0]  model [2**addr_w]; // reference memory image
    logic        exp_valid_1;       // prediction for the request in flight
    logic        exp_valid_2;
    logic        exp_mis_1;
    logic        exp_mis_2;
    logic [31:0] exp_data_1;
    logic [31:0] exp_data_2;
    int          checks;
    int          errors;
    int          cycle_count = 0;
    integer      seed = 32'hf7cf;

    dual_mem_stage #(.ADDRESS_WIDTH(addr_w)) dut_i (.*);

    always #4 clk = ~clk; // 8 ns period

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // half needs bit 0 clear and word needs bits 1:0 clear
    function automatic bit is_misaligned(input logic [2:0] f3, input logic [31:0] a);
        case (f3[1:0])
            2'd1:    return a[0];
            2'd2:    return a[1:0] != 2'd0;
            default: return 1'b0; // bytes
        endcase
    endfunction

    function automatic int access_bytes(input logic [2:0] f3);
        return 1 << f3[1:0];
    endfunction

    // gather little-endian and extend by funct3 bit 2
    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] a);
        logic [31:0] raw;
        int          n;
        raw = '0;
        n   = access_bytes(f3);
        for (int i = 0; i < n; i++) begin
            raw[i*8 +: 8] = model[a[addr_w-1:0] + addr_w'(i)];
        end
        if (!f3[2] && n == 1) begin
            raw = {{24{raw[7]}}, raw[7:0]};
        end else if (!f3[2] && n == 2) begin
            raw = {{16{raw[15]}}, raw[15:0]};
        end
        return raw;
    endfunction

    function automatic void model_store(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] d);
        for (int i = 0; i < access_bytes(f3); i++) begin
            model[a[addr_w-1:0] + addr_w'(i)] = d[i*8 +: 8];
        end
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic check_pipe(input int pipe, input logic v, input logic [31:0] d,
                              input logic m, input logic ev, input logic [31:0] ed,
                              input logic em);
        checks++;
        if (v !== ev) begin
            report_mismatch($sformatf("pipe %0d load_valid %b, expected %b", pipe, v, ev));
        end
        if (m !== em) begin
            report_mismatch($sformatf("pipe %0d misalign %b, expected %b", pipe, m, em));
        end
        if (ev && d !== ed) begin
            report_mismatch($sformatf("pipe %0d load_data %h, expected %h", pipe, d, ed));
        end
    endtask

    // one cycle on both pipes that checks the request sampled at this edge
    task automatic step(input logic r1, input logic w1, input logic [2:0] f1,
                        input logic [31:0] a1, input logic [31:0] d1,
                        input logic r2, input logic w2, input logic [2:0] f2,
                        input logic [31:0] a2, input logic [31:0] d2);
        @(posedge clk);
        req_1    <= r1;
        wr_1     <= w1;
        funct3_1 <= f1;
        addr_1   <= a1;
        wdata_1  <= d1;
        req_2    <= r2;
        wr_2     <= w2;
        funct3_2 <= f2;
        addr_2   <= a2;
        wdata_2  <= d2;
        @(negedge clk);
        check_pipe(1, load_valid_1, load_data_1, misalign_1, exp_valid_1, exp_data_1, exp_mis_1);
        check_pipe(2, load_valid_2, load_data_2, misalign_2, exp_valid_2, exp_data_2, exp_mis_2);
        // loads see memory before the edge so predict before the write
        exp_mis_1   = r1 && is_misaligned(f1, a1);
        exp_mis_2   = r2 && is_misaligned(f2, a2);
        exp_valid_1 = r1 && !w1 && !exp_mis_1;
        exp_valid_2 = r2 && !w2 && !exp_mis_2;
        exp_data_1  = model_load(f1, a1);
        exp_data_2  = model_load(f2, a2);
        if (r1 && w1 && !exp_mis_1) begin
            model_store(f1, a1, d1);
        end
        if (r2 && w2 && !exp_mis_2) begin
            model_store(f2, a2, d2); // pipe 2 goes after pipe 1 and wins on overlap
        end
    endtask

    task automatic loads(input logic [2:0] f1, input logic [31:0] a1,
                         input logic [2:0] f2, input logic [31:0] a2);
        step(1'b1, 1'b0, f1, a1, '0, 1'b1, 1'b0, f2, a2, '0);
    endtask

    task automatic idle();
        step('0, '0, '0, '0, '0, '0, '0, '0, '0, '0); // also drains the last result
    endtask

    task automatic end_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_initial_contents();
        int err0;
        err0 = errors;
        for (int w = 0; w < hex_bytes / 4; w++) begin
            loads(dmem_pkg::f3_lw, 32'(4 * w), dmem_pkg::f3_lhu, 32'(4 * w + 2 * (w % 2)));
            loads(dmem_pkg::f3_lbu, 32'(4 * w + w % 4), dmem_pkg::f3_lw, 32'(60 - 4 * w));
            loads(dmem_pkg::f3_lhu, 32'(60 - 4 * w + 2 * (w % 2)),
                  dmem_pkg::f3_lbu, 32'(60 - 4 * w + w % 4));
        end
        idle();
        end_test("initial contents", err0);
    endtask

    task automatic test_load_extension();
        int err0;
        err0 = errors;
        for (int b = 0; b < hex_bytes; b++) begin // data.hex mixes top bits
            loads(dmem_pkg::f3_lb, 32'(b), dmem_pkg::f3_lbu, 32'(b));
            if (b % 2 == 0) begin
                loads(dmem_pkg::f3_lh, 32'(b), dmem_pkg::f3_lhu, 32'(b));
            end
        end
        idle();
        end_test("load extension", err0);
    endtask

    task automatic test_store_sizes();
        int          err0;
        logic [31:0] d;
        err0 = errors;
        for (int off = 0; off < 4; off++) begin
            d = 32'h1234_5600 + 32'(off * 17);
            step(1, 1, dmem_pkg::f3_sb, 32'(16 + off), d,
                 1, 1, dmem_pkg::f3_sb, 32'(36 + off), ~d);
            loads(dmem_pkg::f3_lw, 32'd16, dmem_pkg::f3_lw, 32'd36);
        end
        for (int off = 0; off < 4; off += 2) begin
            d = 32'hdead_be00 + 32'(off);
            step(1, 1, dmem_pkg::f3_sh, 32'(16 + off), d,
                 1, 1, dmem_pkg::f3_sh, 32'(36 + off), ~d);
            loads(dmem_pkg::f3_lw, 32'd16, dmem_pkg::f3_lw, 32'd36);
        end
        step(1, 1, dmem_pkg::f3_sw, 32'd16, 32'hcafe_f00d,
             1, 1, dmem_pkg::f3_sw, 32'd36, 32'h0bad_c0de);
        loads(dmem_pkg::f3_lw, 32'd16, dmem_pkg::f3_lw, 32'd36);
        idle();
        end_test("store sizes", err0);
    endtask

    task automatic test_collision();
        int err0;
        err0 = errors;
        step(1, 1, dmem_pkg::f3_sw, 32'd40, 32'h1122_3344, 1, 1, dmem_pkg::f3_sb, 32'd41, 32'hee);
        loads(dmem_pkg::f3_lw, 32'd40, dmem_pkg::f3_lw, 32'd40);
        // disjoint halves of one word
        step(1, 1, dmem_pkg::f3_sh, 32'd40, 32'haaaa, 1, 1, dmem_pkg::f3_sh, 32'd42, 32'hbbbb);
        loads(dmem_pkg::f3_lw, 32'd40, dmem_pkg::f3_lbu, 32'd43);
        step(1, 1, dmem_pkg::f3_sw, 32'd44, 32'h0102_0304,
             1, 1, dmem_pkg::f3_sw, 32'd44, 32'h0a0b_0c0d);
        step(1, 1, dmem_pkg::f3_sw, 32'd48, 32'h5566_7788,
             1, 1, dmem_pkg::f3_sh, 32'd50, 32'hc3c3);
        loads(dmem_pkg::f3_lw, 32'd44, dmem_pkg::f3_lw, 32'd48);
        // load beside a store to the same word gets the old word
        step(1, 1, dmem_pkg::f3_sw, 32'd52, 32'h9abc_def0, 1, 0, dmem_pkg::f3_lw, 32'd52, '0);
        step(1, 0, dmem_pkg::f3_lw, 32'd52, '0, 1, 1, dmem_pkg::f3_sb, 32'd53, 32'h7f);
        loads(dmem_pkg::f3_lw, 32'd52, dmem_pkg::f3_lh, 32'd52);
        idle();
        end_test("same-cycle collision", err0);
    endtask

    task automatic test_misalign();
        int err0;
        err0 = errors;
        step(1, 0, dmem_pkg::f3_lh, 32'd1, '0, 1, 1, dmem_pkg::f3_sh, 32'd23, 32'hffff);
        step(1, 0, dmem_pkg::f3_lhu, 32'd7, '0, 1, 1, dmem_pkg::f3_sh, 32'd25, 32'h1234);
        for (int off = 1; off < 4; off++) begin
            step(1, 0, dmem_pkg::f3_lw, 32'(56 + off), '0,
                 1, 1, dmem_pkg::f3_sw, 32'(20 + off), 32'hdead_beef);
        end
        loads(dmem_pkg::f3_lw, 32'd20, dmem_pkg::f3_lw, 32'd24); // untouched words
        idle();
        end_test("misalignment", err0);
    endtask

    // legal aligned operation inside the data.hex region
    task automatic random_op(output logic r, output logic w, output logic [2:0] f,
                             output logic [31:0] a, output logic [31:0] d);
        int pick;
        r    = ($random(seed) & 3) != 0; // busy three cycles in four
        w    = ($random(seed) & 1) != 0;
        pick = $unsigned($random(seed)) % (w ? 3 : 5);
        case (pick)
            0:       f = w ? dmem_pkg::f3_sb : dmem_pkg::f3_lb;
            1:       f = w ? dmem_pkg::f3_sh : dmem_pkg::f3_lh;
            2:       f = w ? dmem_pkg::f3_sw : dmem_pkg::f3_lw;
            3:       f = dmem_pkg::f3_lbu;
            default: f = dmem_pkg::f3_lhu;
        endcase
        a = 32'($unsigned($random(seed)) % hex_bytes);
        a = a & ~32'(access_bytes(f) - 1);
        d = $random(seed);
    endtask

    task automatic test_random_traffic();
        int          err0;
        logic        r1;
        logic        w1;
        logic        r2;
        logic        w2;
        logic [2:0]  f1;
        logic [2:0]  f2;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] d1;
        logic [31:0] d2;
        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            random_op(r1, w1, f1, a1, d1);
            random_op(r2, w2, f2, a2, d2);
            step(r1, w1, f1, a1, d1, r2, w2, f2, a2, d2);
        end
        idle();
        end_test("random traffic", err0);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        arst_n      = 1'b0;
        req_1       = 1'b0;
        wr_1        = 1'b0;
        funct3_1    = '0;
        addr_1      = '0;
        wdata_1     = '0;
        req_2       = 1'b0;
        wr_2        = 1'b0;
        funct3_2    = '0;
        addr_2      = '0;
        wdata_2     = '0;
        exp_valid_1 = 1'b0;
        exp_valid_2 = 1'b0;
        exp_mis_1   = 1'b0;
        exp_mis_2   = 1'b0;
        exp_data_1  = '0;
        exp_data_2  = '0;
        checks      = 0;
        errors      = 0;
        $readmemh("data.hex", model);
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (load_data_1 !== '0 || load_data_2 !== '0) begin
            report_mismatch("load_data not cleared by reset");
        end
        test_initial_contents();
        test_load_extension();
        test_store_sizes();
        test_collision();
        test_misalign();
        test_random_traffic();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dual_mem_stage.f ====
hw/dmem_pkg.sv
hw/data_mem.sv
hw/mem_access_unit.sv
hw/dual_mem_stage.sv
verif/dual_mem_stage_checker.sv
verif/dual_mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dual_mem_stage_tb
RTL_TOP   ?= dual_mem_stage
FILELIST  ?= dual_mem_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed
RTL_SRCS  ?= hw/dmem_pkg.sv hw/data_mem.sv hw/mem_access_unit.sv hw/dual_mem_stage.sv

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== data.hex ====
// one byte per line in hex, byte address 0 upward
07
3c
71
a6
db
10
45
7a
af
e4
19
4e
83
b8
ed
22
57
8c
c1
f6
2b
60
95
ca
ff
34
69
9e
d3
08
3d
72
a7
dc
11
46
7b
b0
e5
1a
4f
84
b9
ee
23
58
8d
c2
f7
2c
61
96
cb
00
35
6a
9f
d4
09
3e
73
a8
dd
12
